/* design/rv_fetch_settings.svh */
`ifndef RV_FETCH_SETTINGS_SVH
`define RV_FETCH_SETTINGS_SVH

// first fetch address out of reset, halfword aligned
`define RV_RESET_VECTOR 32'h0000_0100

`define RV_XLEN 32  // address and word width
`define RV_HALF 16  // halfword width

`endif

/* design/rv_fetch_pkg.sv */
`include "rv_fetch_settings.svh"

package rv_fetch_pkg;

    typedef logic [`RV_XLEN-1:0] addr_t;     // byte address or pc
    typedef logic [`RV_XLEN-1:0] word_t;     // bus word or full instruction
    typedef logic [`RV_HALF-1:0] half_t;     // kept back for realignment
    typedef logic [2:0]          pc_step_t;  // 2 or 4

    // fetch control states
    typedef enum logic [1:0]
    {
        FS_IDLE,
        FS_RUN,
        FS_FLUSH
    } fetch_state_e;

endpackage

/* design/rv_fetch_ctrl.sv */
`timescale 1ns/1ps

module rv_fetch_ctrl
(
    input  logic i_clk,
    input  logic i_reset_n,
    input  logic i_run,
    input  logic i_redirect,
    output logic o_start,
    output logic o_flush,
    output logic o_pc_select
);

    import rv_fetch_pkg::*;

    fetch_state_e state;
    fetch_state_e state_next;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            state <= FS_IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            FS_IDLE:
            begin
                if (i_run)
                    state_next = FS_RUN;
            end
            FS_RUN:
            begin
                if (!i_run)
                    state_next = FS_IDLE;  // stop asking for words
            end
            FS_FLUSH:
            begin
                // single cycle, then back to whatever run says
                if (i_run)
                    state_next = FS_RUN;
                else
                    state_next = FS_IDLE;
            end
            default:
            begin
                state_next = FS_IDLE;
            end
        endcase

        // redirect wins from any state
        if (i_redirect)
            state_next = FS_FLUSH;
    end

    assign o_start     = (state == FS_RUN);
    assign o_flush     = (state == FS_FLUSH);    // drop held halfword
    assign o_pc_select = (state == FS_FLUSH);    // load redirect target

endmodule

/* design/rv_pc_counter.sv */
`timescale 1ns/1ps

`include "rv_fetch_settings.svh"

module rv_pc_counter
(
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic                   i_move,
    input  rv_fetch_pkg::pc_step_t i_pc_incr,
    input  logic                   i_load,
    input  rv_fetch_pkg::addr_t    i_load_pc,
    output rv_fetch_pkg::addr_t    o_pc
);

    import rv_fetch_pkg::*;

    addr_t step;       // zero-extended length
    addr_t load_pc;

    assign step = {{(`RV_XLEN-$bits(pc_step_t)){1'b0}}, i_pc_incr};

    // targets are halfword aligned, bit 0 never reaches the bus
    assign load_pc = {i_load_pc[`RV_XLEN-1:1], 1'b0};

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_pc <= `RV_RESET_VECTOR;
        end
        else if (i_load)
        begin
            o_pc <= load_pc;         // redirect has priority
        end
        else if (i_move)
        begin
            o_pc <= o_pc + step;
        end
    end

endmodule

/* design/rv_fetch_aligner.sv */
`timescale 1ns/1ps

`include "rv_fetch_settings.svh"

module rv_fetch_aligner
(
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  rv_fetch_pkg::addr_t    i_pc,
    input  logic                   i_start,
    input  logic                   i_flush,
    input  logic                   i_pc_select,
    input  rv_fetch_pkg::word_t    i_instruction,
    input  logic                   i_ack,
    output logic                   o_cyc,
    output logic                   o_move,
    output rv_fetch_pkg::pc_step_t o_pc_incr,
    output rv_fetch_pkg::addr_t    o_addr,
    output logic                   o_ready,
    output logic                   o_valid,
    output rv_fetch_pkg::addr_t    o_pc,
    output rv_fetch_pkg::word_t    o_instruction
);

    import rv_fetch_pkg::*;

    logic  bus_cyc;
    logic  bus_done;     // ack on an active cycle
    logic  pc_odd;       // pc at offset 2
    logic  misal;        // hold_hw is the low half of a straddling instr
    logic  is_long;
    logic  complete;
    half_t hold_hw;
    half_t data_lo;
    half_t data_hi;
    half_t first_hw;
    half_t second_hw;
    word_t instr_mux;
    addr_t word_addr;
    logic  valid_q;
    addr_t pc_q;
    word_t instr_q;

    assign bus_cyc  = i_start;
    assign bus_done = bus_cyc & i_ack;
    assign pc_odd   = i_pc[1];

    assign data_lo = i_instruction[`RV_HALF-1:0];
    assign data_hi = i_instruction[`RV_XLEN-1:`RV_HALF];

    // word holding the pc, stepped to the next one while a low half is kept
    assign word_addr = {i_pc[`RV_XLEN-1:2], 2'b00};
    assign o_addr    = misal ? word_addr + addr_t'(4) : word_addr;

    // halfword at the pc, then the one after it
    assign first_hw  = !pc_odd ? data_lo : (misal ? hold_hw : data_hi);
    assign second_hw = pc_odd ? data_lo : data_hi;

    assign is_long  = (first_hw[1:0] == 2'b11);
    assign complete = !(pc_odd & !misal & is_long);  // upper half only so far

    assign instr_mux = is_long ? {second_hw, first_hw}
                               : {{(`RV_XLEN-`RV_HALF){1'b0}}, first_hw};

    always_ff @(posedge i_clk)
    begin
        if (bus_done)
            hold_hw <= data_hi;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n || i_flush)
            misal <= 1'b0;
        else if (bus_done)
            misal <= pc_odd & !misal & is_long;
    end

    // output stage, strobe lines up with pc and instruction
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            valid_q <= 1'b0;
        else
            valid_q <= o_ready;
    end

    always_ff @(posedge i_clk)
    begin
        if (o_ready)
        begin
            pc_q    <= i_pc;
            instr_q <= instr_mux;
        end
    end

    assign o_cyc         = bus_cyc;
    assign o_ready       = bus_done & complete;
    assign o_move        = o_ready | i_pc_select;
    assign o_pc_incr     = is_long ? 3'd4 : 3'd2;
    assign o_valid       = valid_q;
    assign o_pc          = pc_q;
    assign o_instruction = instr_q;

endmodule

/* design/rv_fetch_top.sv */
`timescale 1ns/1ps

module rv_fetch_top
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_run,
    input  logic                i_redirect,
    input  rv_fetch_pkg::addr_t i_redirect_pc,
    input  rv_fetch_pkg::word_t i_bus_data,
    input  logic                i_bus_ack,
    output logic                o_bus_cyc,
    output rv_fetch_pkg::addr_t o_bus_addr,
    output logic                o_valid,
    output rv_fetch_pkg::addr_t o_pc,
    output rv_fetch_pkg::word_t o_instr
);

    import rv_fetch_pkg::*;

    logic     fetch_start;
    logic     fetch_flush;
    logic     pc_select;
    logic     pc_move;
    pc_step_t pc_incr;
    addr_t    fetch_pc;     // architectural fetch pc

    rv_fetch_ctrl ctrl_i
    (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_run       (i_run),
        .i_redirect  (i_redirect),
        .o_start     (fetch_start),
        .o_flush     (fetch_flush),
        .o_pc_select (pc_select)
    );

    rv_pc_counter pc_i
    (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_move      (pc_move),
        .i_pc_incr   (pc_incr),
        .i_load      (pc_select),
        .i_load_pc   (i_redirect_pc),
        .o_pc        (fetch_pc)
    );

    rv_fetch_aligner aligner_i
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_pc          (fetch_pc),
        .i_start       (fetch_start),
        .i_flush       (fetch_flush),
        .i_pc_select   (pc_select),
        .i_instruction (i_bus_data),
        .i_ack         (i_bus_ack),
        .o_cyc         (o_bus_cyc),
        .o_move        (pc_move),
        .o_pc_incr     (pc_incr),
        .o_addr        (o_bus_addr),
        .o_ready       (),
        .o_valid       (o_valid),
        .o_pc          (o_pc),
        .o_instruction (o_instr)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
)
(
    output logic o_clk,
    output logic o_reset_n
);

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial
    begin
        o_reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_reset_n = 1'b1;  // released on a falling edge
    end

endmodule

/* verification/tb_rv_fetch.sv */
`timescale 1ns/1ps

`include "rv_fetch_settings.svh"

module tb_rv_fetch;

    import rv_fetch_pkg::*;

    localparam int          RESET_CYCLES   = 10;
    localparam int          MEM_AW         = 10;   // halfword index bits
    localparam int          QUEUE_FILL     = 128;
    localparam int          PAUSE_CYCLES   = 8;
    localparam int          N_TOTAL        = 40 + 40 + 20 + 30 + 30;
    localparam int          TIMEOUT_CYCLES = RESET_CYCLES + 40 * N_TOTAL;
    localparam logic [31:0] LFSR_SEED      = 32'h7903;

    logic  i_clk;
    logic  i_reset_n;
    logic  i_run;
    logic  i_redirect;
    addr_t i_redirect_pc;
    word_t i_bus_data;
    logic  i_bus_ack;
    logic  o_bus_cyc;
    addr_t o_bus_addr;
    logic  o_valid;
    addr_t o_pc;
    word_t o_instr;

    half_t       mem [0:(1 << MEM_AW) - 1];
    logic [31:0] lfsr_state;
    logic        random_delays;
    int          rx_count;
    addr_t       exp_pc_q[$];
    word_t       exp_instr_q[$];

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i
    (
        .o_clk     (i_clk),
        .o_reset_n (i_reset_n)
    );

    rv_fetch_top dut_i
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_run         (i_run),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_bus_data    (i_bus_data),
        .i_bus_ack     (i_bus_ack),
        .o_bus_cyc     (o_bus_cyc),
        .o_bus_addr    (o_bus_addr),
        .o_valid       (o_valid),
        .o_pc          (o_pc),
        .o_instr       (o_instr)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic fill_memory();
        logic [31:0] bits;
        for (int i = 0; i < (1 << MEM_AW); i++)
        begin
            take_bits(17, bits);
            mem[i] = bits[15:0];
            if (bits[16])
                mem[i][1:0] = 2'b11;               // 32-bit opcode
            else if (mem[i][1:0] == 2'b11)
                mem[i][1:0] = 2'b01;
        end
    endtask

    function automatic word_t mem_word(input addr_t addr);
        logic [MEM_AW-1:0] idx;
        logic [MEM_AW-1:0] idx_next;
        idx      = addr[MEM_AW:1];
        idx_next = idx + 1'b1;
        return {mem[idx_next], mem[idx]};
    endfunction

    // expected instruction at pc, zero-extended if compressed
    function automatic word_t ref_fetch(input addr_t pc, output pc_step_t len);
        logic [MEM_AW-1:0] idx;
        logic [MEM_AW-1:0] idx_next;
        half_t             first;
        idx      = pc[MEM_AW:1];
        idx_next = idx + 1'b1;
        first    = mem[idx];
        if (first[1:0] == 2'b11)
        begin
            len = 3'd4;
            return {mem[idx_next], first};
        end
        len = 3'd2;
        return {{(`RV_XLEN-`RV_HALF){1'b0}}, first};
    endfunction

    task automatic expect_from(input addr_t start_pc);
        addr_t    pc;
        pc_step_t len;
        word_t    instr;
        exp_pc_q.delete();
        exp_instr_q.delete();
        pc = start_pc;
        for (int i = 0; i < QUEUE_FILL; i++)
        begin
            instr = ref_fetch(pc, len);
            exp_pc_q.push_back(pc);
            exp_instr_q.push_back(instr);
            pc = pc + addr_t'(len);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERROR at %0d ns: %s is %b, expected %b",
                                $time, what, got, exp));
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERROR at %0d ns: %s is %h, expected %h",
                                $time, what, got, exp));
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERROR at %0d ns: %s is %h, expected %h",
                                $time, what, got, exp));
    endtask

    // waits on delivered instructions, counted by the compare process
    task automatic wait_instr(input int n);
        int target;
        @(posedge i_clk);
        target = rx_count + n;
        while (rx_count < target)
            @(posedge i_clk);
        @(negedge i_clk);
    endtask

    task automatic start_run();
        i_run = 1'b1;
        @(negedge i_clk);
        check_bit(o_bus_cyc, 1'b1, "o_bus_cyc one cycle after i_run");
    endtask

    task automatic pause_run(input logic delays);
        i_run = 1'b0;
        @(negedge i_clk);
        check_bit(o_bus_cyc, 1'b0, "o_bus_cyc after i_run low");
        random_delays = delays;  // bus idle, model draws nothing now
        repeat (PAUSE_CYCLES)
        begin
            @(negedge i_clk);
            check_bit(o_bus_cyc, 1'b0, "o_bus_cyc while i_run low");
            check_bit(o_valid, 1'b0, "o_valid while i_run low");
        end
    endtask

    task automatic redirect_to(input addr_t target);
        i_redirect    = 1'b1;
        i_redirect_pc = target;  // held through the flush cycle
        @(negedge i_clk);
        i_redirect = 1'b0;
        check_bit(o_bus_cyc, 1'b0, "o_bus_cyc in the flush cycle");
        @(posedge i_clk);
        expect_from(target);     // drops whatever was in flight
    endtask

    initial
    begin : memory_model
        int          wait_cnt;
        logic [31:0] bits;
        i_bus_ack  = 1'b0;
        i_bus_data = '0;
        wait_cnt   = 0;
        forever
        begin
            @(negedge i_clk);
            i_bus_ack = 1'b0;
            if (i_reset_n && o_bus_cyc)
            begin
                // bus is word addressed
                check_bit(o_bus_addr[1] | o_bus_addr[0], 1'b0, "o_bus_addr offset");
                if (wait_cnt == 0)
                begin
                    i_bus_ack  = 1'b1;
                    i_bus_data = mem_word(o_bus_addr);
                    if (random_delays)
                    begin
                        take_bits(2, bits);
                        wait_cnt = int'(bits[1:0]);  // 0 to 3 cycles
                    end
                end
                else
                begin
                    wait_cnt = wait_cnt - 1;
                end
            end
        end
    end

    always @(negedge i_clk)
    begin : compare_outputs
        addr_t pc_e;
        word_t instr_e;
        if (i_reset_n && o_valid)
        begin
            if (exp_pc_q.size() == 0)
            begin
                abort_run("o_valid came with no instruction left to expect");
            end
            else
            begin
                pc_e    = exp_pc_q.pop_front();
                instr_e = exp_instr_q.pop_front();
                check_addr(o_pc, pc_e, "o_pc");
                check_word(o_instr, instr_e, $sformatf("o_instr at pc %h", pc_e));
                rx_count = rx_count + 1;
            end
        end
    end

    initial
    begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge i_clk);
        abort_run("The run hung: the tests did not finish in the time allowed.");
    end

    initial
    begin : stimulus
        i_run         = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = `RV_RESET_VECTOR;
        random_delays = 1'b0;
        rx_count      = 0;
        lfsr_state    = LFSR_SEED;
        fill_memory();
        expect_from(`RV_RESET_VECTOR);

        @(posedge i_reset_n);
        repeat (10)
        begin
            @(negedge i_clk);
            check_bit(o_valid, 1'b0, "o_valid before i_run");
            check_bit(o_bus_cyc, 1'b0, "o_bus_cyc before i_run");
        end

        // straight line, ack in the first bus cycle
        start_run();
        wait_instr(40);

        pause_run(1'b1);
        start_run();
        wait_instr(40);
        pause_run(1'b1);
        start_run();
        wait_instr(20);

        redirect_to(32'h0000_02a2);  // offset 2
        wait_instr(30);
        redirect_to(32'h0000_0400);
        wait_instr(30);

        i_run = 1'b0;
        repeat (PAUSE_CYCLES) @(negedge i_clk);
        if (!o_bus_cyc && !o_valid)
        begin
            $display("Test OK");
            $finish;
        end
        else
        begin
            abort_run("The bus was still active or o_valid was high after i_run went low.");
        end
    end

endmodule

/* vlog.f */
+incdir+design
design/rv_fetch_pkg.sv
design/rv_fetch_ctrl.sv
design/rv_pc_counter.sv
design/rv_fetch_aligner.sv
design/rv_fetch_top.sv
verification/tb_clock_gen.sv
verification/tb_rv_fetch.sv

/* Bender.yml */
package:
  name: rv_fetch

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/rv_fetch_pkg.sv
      - design/rv_fetch_ctrl.sv
      - design/rv_pc_counter.sv
      - design/rv_fetch_aligner.sv
      - design/rv_fetch_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_rv_fetch.sv
